/* design/lpf_defs.svh */
// Filter constants shared by the interpolator chain
// Coefficients are odd-phase half-band taps in Q(LPF_COEF_FRAC)
// Twice their sum is 2**LPF_COEF_FRAC, so passband gain is unity
`ifndef LPF_DEFS_SVH
`define LPF_DEFS_SVH

`define LPF_COEF_FRAC   13

// C0 is the innermost symmetric pair
`define LPF_HB_C0       (18'sd4871)
`define LPF_HB_C1       (-18'sd1049)
`define LPF_HB_C2       (18'sd331)
`define LPF_HB_C3       (-18'sd57)

// Input samples kept per interpolator
`define LPF_HB_HIST     8

`define LPF_FIFO_DEPTH  4

`endif

/* design/lpf_pkg.sv */
// Types shared by the stereo interpolator chain
// Accumulator width follows a DSP48-style 48-bit accumulator
package lpf_pkg;

    typedef logic signed [17:0] lpf_sample_t;
    typedef logic signed [17:0] lpf_coef_t;
    typedef logic signed [47:0] lpf_acc_t;

    // Owner of the shared MAC
    typedef enum logic {
        CLIENT_HB1,
        CLIENT_HB2
    } lpf_client_t;

    // Sequencer program steps
    typedef enum logic [2:0] {
        WAIT_IN,
        WAIT_HB1,
        POP_1_2,
        WAIT_HB2_A,
        POP_1_2_B,
        WAIT_HB2_B
    } lpf_seq_state_t;

endpackage

/* design/sample_fifo.sv */
// Show-ahead FIFO for stereo sample pairs, head visible without a read
// Push when full and pop when empty are both ignored
`timescale 1ns/1ps
`include "lpf_defs.svh"

module sample_fifo import lpf_pkg::*; #(
    parameter int DEPTH = `LPF_FIFO_DEPTH
) (
    input  logic        reset,
    input  logic        clk,
    input  logic        push,
    input  logic        pop,
    input  lpf_sample_t data_in_l,
    input  lpf_sample_t data_in_r,
    output lpf_sample_t data_out_l,
    output lpf_sample_t data_out_r,
    output logic        empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [35:0]      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign do_push = push && (count != CNT_W'(DEPTH));
    assign do_pop  = pop && !empty;

    // Left sample in the upper half of each entry
    assign data_out_l = mem[rd_ptr][35:18];
    assign data_out_r = mem[rd_ptr][17:0];

    always_ff @(posedge reset) begin
        if (do_push) begin
            mem[wr_ptr] <= {data_in_l, data_in_r};
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/mac_unit.sv */
// Shared two-lane pre-add, multiply, accumulate unit
// Result appears two cycles after the issuing cycle
// Only the client named by mac_owner reaches the datapath
`timescale 1ns/1ps

module mac_unit import lpf_pkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  lpf_client_t mac_owner,
    input  logic        hb1_mac_en,
    input  logic        hb1_mac_clear,
    input  lpf_coef_t   hb1_mac_coef,
    input  lpf_sample_t hb1_mac_a_l,
    input  lpf_sample_t hb1_mac_b_l,
    input  lpf_sample_t hb1_mac_a_r,
    input  lpf_sample_t hb1_mac_b_r,
    input  logic        hb2_mac_en,
    input  logic        hb2_mac_clear,
    input  lpf_coef_t   hb2_mac_coef,
    input  lpf_sample_t hb2_mac_a_l,
    input  lpf_sample_t hb2_mac_b_l,
    input  lpf_sample_t hb2_mac_a_r,
    input  lpf_sample_t hb2_mac_b_r,
    output lpf_acc_t    acc_l,
    output lpf_acc_t    acc_r
);

    logic               sel_en;
    logic               sel_clear;
    lpf_coef_t          sel_coef;
    logic signed [18:0] pre_l;
    logic signed [18:0] pre_r;
    logic signed [36:0] prod_l;
    logic signed [36:0] prod_r;
    logic               en_q;
    logic               clear_q;

    // ------------------------------------------------------------
    // Owner mux and pre-adders
    // ------------------------------------------------------------
    always_comb begin
        if (mac_owner == CLIENT_HB1) begin
            sel_en    = hb1_mac_en;
            sel_clear = hb1_mac_clear;
            sel_coef  = hb1_mac_coef;
            pre_l     = 19'(hb1_mac_a_l) + 19'(hb1_mac_b_l);
            pre_r     = 19'(hb1_mac_a_r) + 19'(hb1_mac_b_r);
        end else begin
            sel_en    = hb2_mac_en;
            sel_clear = hb2_mac_clear;
            sel_coef  = hb2_mac_coef;
            pre_l     = 19'(hb2_mac_a_l) + 19'(hb2_mac_b_l);
            pre_r     = 19'(hb2_mac_a_r) + 19'(hb2_mac_b_r);
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            en_q    <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            en_q    <= sel_en;
            clear_q <= sel_en && sel_clear;
        end
    end

    // Stage one multiply, stage two load or accumulate
    always_ff @(posedge reset) begin
        if (sel_en) begin
            prod_l <= pre_l * sel_coef;
            prod_r <= pre_r * sel_coef;
        end
        if (en_q) begin
            acc_l <= clear_q ? lpf_acc_t'(prod_l) : acc_l + lpf_acc_t'(prod_l);
            acc_r <= clear_q ? lpf_acc_t'(prod_r) : acc_r + lpf_acc_t'(prod_r);
        end
    end

endmodule

/* design/halfband_interp.sv */
// Stereo 2x half-band interpolator on a shared MAC
// Even output one cycle after start, odd output and done eight cycles after
// A start while busy restarts the sequence
// MAC outputs are zero while idle so the owner mux sees clean inputs
`timescale 1ns/1ps
`include "lpf_defs.svh"

module halfband_interp import lpf_pkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  logic        start,
    input  lpf_sample_t sample_in_l,
    input  lpf_sample_t sample_in_r,
    input  lpf_acc_t    acc_l,
    input  lpf_acc_t    acc_r,
    output logic        mac_en,
    output logic        mac_clear,
    output lpf_coef_t   mac_coef,
    output lpf_sample_t mac_a_l,
    output lpf_sample_t mac_b_l,
    output lpf_sample_t mac_a_r,
    output lpf_sample_t mac_b_r,
    output logic        sample_out_rdy,
    output lpf_sample_t sample_out_l,
    output lpf_sample_t sample_out_r,
    output logic        done
);

    localparam lpf_acc_t RND_HALF = lpf_acc_t'(1) << (`LPF_COEF_FRAC - 1);
    localparam lpf_acc_t SAT_MAX  = 48'sd131071;
    localparam lpf_acc_t SAT_MIN  = -48'sd131072;

    lpf_sample_t hist_l [`LPF_HB_HIST];
    lpf_sample_t hist_r [`LPF_HB_HIST];
    logic        busy;
    logic [2:0]  step;
    logic [1:0]  tap;
    logic [2:0]  idx_a;
    logic [2:0]  idx_b;
    lpf_acc_t    rnd_l;
    lpf_acc_t    rnd_r;
    lpf_acc_t    shift_l;
    lpf_acc_t    shift_r;
    lpf_sample_t odd_l;
    lpf_sample_t odd_r;

    // ------------------------------------------------------------
    // Tap issue, steps 1 to 4
    // ------------------------------------------------------------
    assign tap   = 2'(step - 3'd1);
    assign idx_a = 3'd3 - {1'b0, tap};
    assign idx_b = 3'd4 + {1'b0, tap};

    always_comb begin
        mac_en    = 1'b0;
        mac_clear = 1'b0;
        mac_coef  = '0;
        mac_a_l   = '0;
        mac_b_l   = '0;
        mac_a_r   = '0;
        mac_b_r   = '0;
        if (busy && step <= 3'd4) begin
            mac_en    = 1'b1;
            mac_clear = (step == 3'd1);
            mac_a_l   = hist_l[idx_a];
            mac_b_l   = hist_l[idx_b];
            mac_a_r   = hist_r[idx_a];
            mac_b_r   = hist_r[idx_b];
            case (tap)
                2'd0:    mac_coef = `LPF_HB_C0;
                2'd1:    mac_coef = `LPF_HB_C1;
                2'd2:    mac_coef = `LPF_HB_C2;
                default: mac_coef = `LPF_HB_C3;
            endcase
        end
    end

    // Drop fraction bits, then clamp to 18 bits
    always_comb begin
        shift_l = rnd_l >>> `LPF_COEF_FRAC;
        shift_r = rnd_r >>> `LPF_COEF_FRAC;
        if (shift_l > SAT_MAX) begin
            odd_l = 18'sh1ffff;
        end else if (shift_l < SAT_MIN) begin
            odd_l = 18'sh20000;
        end else begin
            odd_l = shift_l[17:0];
        end
        if (shift_r > SAT_MAX) begin
            odd_r = 18'sh1ffff;
        end else if (shift_r < SAT_MIN) begin
            odd_r = 18'sh20000;
        end else begin
            odd_r = shift_r[17:0];
        end
    end

    // ------------------------------------------------------------
    // Control and history
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            busy           <= 1'b0;
            step           <= '0;
            sample_out_rdy <= 1'b0;
            done           <= 1'b0;
            for (int i = 0; i < `LPF_HB_HIST; i++) begin
                hist_l[i] <= '0;
                hist_r[i] <= '0;
            end
        end else begin
            sample_out_rdy <= 1'b0;
            done           <= 1'b0;
            if (start) begin
                // h0 is the newest sample
                for (int i = `LPF_HB_HIST - 1; i > 0; i--) begin
                    hist_l[i] <= hist_l[i-1];
                    hist_r[i] <= hist_r[i-1];
                end
                hist_l[0]      <= sample_in_l;
                hist_r[0]      <= sample_in_r;
                busy           <= 1'b1;
                step           <= 3'd1;
                sample_out_rdy <= 1'b1;
            end else if (busy) begin
                step <= step + 3'd1;
                if (step == 3'd7) begin
                    busy           <= 1'b0;
                    sample_out_rdy <= 1'b1;
                    done           <= 1'b1;
                end
            end
        end
    end

    // Accumulator is valid at step 6
    always_ff @(posedge reset) begin
        if (busy && step == 3'd6) begin
            rnd_l <= acc_l + RND_HALF;
            rnd_r <= acc_r + RND_HALF;
        end
        if (start) begin
            // h3 of the shifted history is h2 before the shift
            sample_out_l <= hist_l[2];
            sample_out_r <= hist_r[2];
        end else if (busy && step == 3'd7) begin
            sample_out_l <= odd_l;
            sample_out_r <= odd_r;
        end
    end

endmodule

/* design/interp_sequencer.sv */
// Fixed-schedule sequencer for the two interpolator stages
// Owns MAC arbitration; there is no request/grant handshake
// Input strobes outside WAIT_IN are dropped
`timescale 1ns/1ps

module interp_sequencer import lpf_pkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  logic        sample_in_rdy,
    input  logic        hb1_done,
    input  logic        hb2_done,
    output logic        hb1_start,
    output logic        hb2_start,
    output logic        fifo_pop,
    output lpf_client_t mac_owner
);

    lpf_seq_state_t state;
    lpf_seq_state_t state_next;

    // ------------------------------------------------------------
    // Program step
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state <= WAIT_IN;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WAIT_IN: begin
                if (sample_in_rdy) begin
                    state_next = WAIT_HB1;
                end
            end
            WAIT_HB1: begin
                if (hb1_done) begin
                    state_next = POP_1_2;
                end
            end
            POP_1_2: begin
                state_next = WAIT_HB2_A;
            end
            WAIT_HB2_A: begin
                if (hb2_done) begin
                    state_next = POP_1_2_B;
                end
            end
            POP_1_2_B: begin
                state_next = WAIT_HB2_B;
            end
            WAIT_HB2_B: begin
                if (hb2_done) begin
                    state_next = WAIT_IN;
                end
            end
            default: begin
                state_next = WAIT_IN;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Strobes and MAC ownership
    // ------------------------------------------------------------
    assign hb1_start = (state == WAIT_IN) && sample_in_rdy;

    // Stage 2 captures the FIFO head in the pop cycle
    assign fifo_pop  = (state == POP_1_2) || (state == POP_1_2_B);
    assign hb2_start = fifo_pop;

    assign mac_owner = ((state == WAIT_IN) || (state == WAIT_HB1)) ? CLIENT_HB1
                                                                   : CLIENT_HB2;

endmodule

/* design/interp_chain.sv */
// Stereo 4x interpolator, two half-band stages on one MAC
// Inputs must be at least 32 cycles apart, earlier strobes are dropped
// Output order per input is e0, o0, e1, o1 with no back-pressure
`timescale 1ns/1ps
`include "lpf_defs.svh"

module interp_chain import lpf_pkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  logic        sample_in_rdy,
    input  lpf_sample_t sample_in_l,
    input  lpf_sample_t sample_in_r,
    output logic        sample_out_rdy,
    output lpf_sample_t sample_out_l,
    output lpf_sample_t sample_out_r
);

    logic        hb1_start;
    logic        hb2_start;
    logic        hb1_done;
    logic        hb2_done;
    logic        fifo_pop;
    lpf_client_t mac_owner;

    logic        hb1_out_rdy;
    lpf_sample_t hb1_out_l;
    lpf_sample_t hb1_out_r;
    lpf_sample_t hb2_in_l;
    lpf_sample_t hb2_in_r;

    logic        hb1_mac_en;
    logic        hb1_mac_clear;
    lpf_coef_t   hb1_mac_coef;
    lpf_sample_t hb1_mac_a_l;
    lpf_sample_t hb1_mac_b_l;
    lpf_sample_t hb1_mac_a_r;
    lpf_sample_t hb1_mac_b_r;
    logic        hb2_mac_en;
    logic        hb2_mac_clear;
    lpf_coef_t   hb2_mac_coef;
    lpf_sample_t hb2_mac_a_l;
    lpf_sample_t hb2_mac_b_l;
    lpf_sample_t hb2_mac_a_r;
    lpf_sample_t hb2_mac_b_r;
    lpf_acc_t    acc_l;
    lpf_acc_t    acc_r;

    interp_sequencer u_seq (
        .reset         (reset),
        .clk           (clk),
        .sample_in_rdy (sample_in_rdy),
        .hb1_done      (hb1_done),
        .hb2_done      (hb2_done),
        .hb1_start     (hb1_start),
        .hb2_start     (hb2_start),
        .fifo_pop      (fifo_pop),
        .mac_owner     (mac_owner)
    );

    halfband_interp u_hb1 (
        .reset          (reset),
        .clk            (clk),
        .start          (hb1_start),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .acc_l          (acc_l),
        .acc_r          (acc_r),
        .mac_en         (hb1_mac_en),
        .mac_clear      (hb1_mac_clear),
        .mac_coef       (hb1_mac_coef),
        .mac_a_l        (hb1_mac_a_l),
        .mac_b_l        (hb1_mac_b_l),
        .mac_a_r        (hb1_mac_a_r),
        .mac_b_r        (hb1_mac_b_r),
        .sample_out_rdy (hb1_out_rdy),
        .sample_out_l   (hb1_out_l),
        .sample_out_r   (hb1_out_r),
        .done           (hb1_done)
    );

    // Stage 1 to stage 2, at most two entries in flight
    sample_fifo #(.DEPTH(`LPF_FIFO_DEPTH)) u_fifo (
        .reset      (reset),
        .clk        (clk),
        .push       (hb1_out_rdy),
        .pop        (fifo_pop),
        .data_in_l  (hb1_out_l),
        .data_in_r  (hb1_out_r),
        .data_out_l (hb2_in_l),
        .data_out_r (hb2_in_r),
        .empty      ()
    );

    halfband_interp u_hb2 (
        .reset          (reset),
        .clk            (clk),
        .start          (hb2_start),
        .sample_in_l    (hb2_in_l),
        .sample_in_r    (hb2_in_r),
        .acc_l          (acc_l),
        .acc_r          (acc_r),
        .mac_en         (hb2_mac_en),
        .mac_clear      (hb2_mac_clear),
        .mac_coef       (hb2_mac_coef),
        .mac_a_l        (hb2_mac_a_l),
        .mac_b_l        (hb2_mac_b_l),
        .mac_a_r        (hb2_mac_a_r),
        .mac_b_r        (hb2_mac_b_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r),
        .done           (hb2_done)
    );

    mac_unit u_mac (
        .reset         (reset),
        .clk           (clk),
        .mac_owner     (mac_owner),
        .hb1_mac_en    (hb1_mac_en),
        .hb1_mac_clear (hb1_mac_clear),
        .hb1_mac_coef  (hb1_mac_coef),
        .hb1_mac_a_l   (hb1_mac_a_l),
        .hb1_mac_b_l   (hb1_mac_b_l),
        .hb1_mac_a_r   (hb1_mac_a_r),
        .hb1_mac_b_r   (hb1_mac_b_r),
        .hb2_mac_en    (hb2_mac_en),
        .hb2_mac_clear (hb2_mac_clear),
        .hb2_mac_coef  (hb2_mac_coef),
        .hb2_mac_a_l   (hb2_mac_a_l),
        .hb2_mac_b_l   (hb2_mac_b_l),
        .hb2_mac_a_r   (hb2_mac_a_r),
        .hb2_mac_b_r   (hb2_mac_b_r),
        .acc_l         (acc_l),
        .acc_r         (acc_r)
    );

endmodule

/* sim/tb_interp_chain.sv */
// Testbench for the stereo 4x interpolator chain
// The reset port carries the clock and the clk port the active-high reset
// Inputs are spaced 40 cycles apart to clear the 32-cycle minimum
// Expected samples come from a behavioral model of both half-band stages
`timescale 1ns/1ps
`include "lpf_defs.svh"

module tb_interp_chain import lpf_pkg::*;;

    localparam int N_IMPULSE = 8;
    localparam int N_DC      = 14;
    localparam int N_RAND    = 200;
    localparam int N_ALT     = 17;
    localparam int N_DROP    = 1;
    localparam int SPACING   = 40;
    localparam int TIMEOUT_CYCLES =
        (N_IMPULSE + N_DC + N_RAND + N_ALT + N_DROP) * SPACING + 200;

    localparam lpf_sample_t DC_L   = 18'sd100000;
    localparam lpf_sample_t DC_R   = -18'sd54321;
    localparam lpf_sample_t FS_POS = 18'sd131071;
    localparam lpf_sample_t FS_NEG = -18'sd131072;

    logic        reset;
    logic        clk;
    logic        sample_in_rdy;
    lpf_sample_t sample_in_l;
    lpf_sample_t sample_in_r;
    logic        sample_out_rdy;
    lpf_sample_t sample_out_l;
    lpf_sample_t sample_out_r;

    // Model history indexed by stage, channel (left 0) and age (newest 0)
    lpf_sample_t mh [2][2][`LPF_HB_HIST];
    lpf_sample_t exp_l [$];
    lpf_sample_t exp_r [$];
    lpf_sample_t last_l [4];
    lpf_sample_t last_r [4];
    int          out_count = 0;
    int          err_count = 0;
    int          sat_count = 0;
    int          cycle_count;
    int          seed = 32'h54de590e;
    logic        right_zero = 1'b0;

    interp_chain u_interp_chain (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in_l    (sample_in_l),
        .sample_in_r    (sample_in_r),
        .sample_out_rdy (sample_out_rdy),
        .sample_out_l   (sample_out_l),
        .sample_out_r   (sample_out_r)
    );

    initial begin
        reset = 1'b0;
        forever #5 reset = ~reset;
    end

    // ------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------
    task automatic stop_run(input string why);
        err_count++;
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic report_error(input string msg);
        err_count++;
        $display("[ERROR] %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1, "Value mismatch");
    endtask

    task automatic check_sample(input string what, input lpf_sample_t got,
                                input lpf_sample_t want);
        if (got !== want) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic check_strobe(input string what, input logic got, input logic want);
        if (got !== want) begin
            report_error($sformatf("%s is %b, expected %b", what, got, want));
        end
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            report_error($sformatf("%s is %0d, expected %0d", what, got, want));
        end
    endtask

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic void shift_in(input int s, input lpf_sample_t xl,
                                     input lpf_sample_t xr);
        for (int i = `LPF_HB_HIST - 1; i > 0; i--) begin
            mh[s][0][i] = mh[s][0][i-1];
            mh[s][1][i] = mh[s][1][i-1];
        end
        mh[s][0][0] = xl;
        mh[s][1][0] = xr;
    endfunction

    // Symmetric taps with round half up and an 18-bit clamp
    function automatic lpf_sample_t odd_phase(input int s, input int c);
        longint acc;
        longint res;
        acc = longint'(`LPF_HB_C0) * (longint'(mh[s][c][3]) + longint'(mh[s][c][4]))
            + longint'(`LPF_HB_C1) * (longint'(mh[s][c][2]) + longint'(mh[s][c][5]))
            + longint'(`LPF_HB_C2) * (longint'(mh[s][c][1]) + longint'(mh[s][c][6]))
            + longint'(`LPF_HB_C3) * (longint'(mh[s][c][0]) + longint'(mh[s][c][7]));
        res = (acc + (longint'(1) << (`LPF_COEF_FRAC - 1))) >>> `LPF_COEF_FRAC;
        if (res > 131071) begin
            sat_count++;
            return FS_POS;
        end
        if (res < -131072) begin
            sat_count++;
            return FS_NEG;
        end
        return lpf_sample_t'(res);
    endfunction

    function automatic void hb_model(input lpf_sample_t xl, input lpf_sample_t xr);
        lpf_sample_t e_l;
        lpf_sample_t e_r;
        lpf_sample_t o_l;
        lpf_sample_t o_r;
        shift_in(0, xl, xr);
        e_l = mh[0][0][3];
        e_r = mh[0][1][3];
        o_l = odd_phase(0, 0);
        o_r = odd_phase(0, 1);
        // Stage 2 takes the even sample first, then the odd one
        shift_in(1, e_l, e_r);
        exp_l.push_back(mh[1][0][3]);
        exp_r.push_back(mh[1][1][3]);
        exp_l.push_back(odd_phase(1, 0));
        exp_r.push_back(odd_phase(1, 1));
        shift_in(1, o_l, o_r);
        exp_l.push_back(mh[1][0][3]);
        exp_r.push_back(mh[1][1][3]);
        exp_l.push_back(odd_phase(1, 0));
        exp_r.push_back(odd_phase(1, 1));
    endfunction

    // One input strobe plus an optional extra strobe drop_at cycles later
    task automatic send_sample(input lpf_sample_t l, input lpf_sample_t r,
                               input int drop_at);
        int n;
        @(posedge reset);
        sample_in_rdy <= 1'b1;
        sample_in_l   <= l;
        sample_in_r   <= r;
        hb_model(l, r);
        n = 0;
        do begin
            @(posedge reset);
            n++;
            if (n == drop_at) begin
                sample_in_rdy <= 1'b1;
                sample_in_l   <= ~l;
                sample_in_r   <= ~r;
            end else begin
                sample_in_rdy <= 1'b0;
            end
        end while (exp_l.size() != 0 || n <= drop_at);
        while (n < SPACING - 1) begin
            @(posedge reset);
            n++;
        end
    endtask

    // ------------------------------------------------------------
    // Output monitor and timeout
    // ------------------------------------------------------------
    initial begin
        lpf_sample_t want_l;
        lpf_sample_t want_r;
        forever begin
            @(negedge reset);
            if (sample_out_rdy === 1'b1) begin
                if (exp_l.size() == 0) begin
                    stop_run("Output strobe arrived with no sample expected");
                end else begin
                    want_l = exp_l.pop_front();
                    want_r = exp_r.pop_front();
                    check_sample("sample_out_l", sample_out_l, want_l);
                    check_sample("sample_out_r", sample_out_r, want_r);
                    if (right_zero) begin
                        check_sample("right lane during left impulse", sample_out_r, '0);
                    end
                    last_l[out_count % 4] = sample_out_l;
                    last_r[out_count % 4] = sample_out_r;
                    out_count++;
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge reset);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                stop_run($sformatf("Timeout after %0d cycles, outputs stopped", cycle_count));
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        lpf_sample_t vl;
        lpf_sample_t vr;
        int          sat_before;
        int          cnt_before;
        clk           = 1'b1;
        sample_in_rdy = 1'b0;
        sample_in_l   = '0;
        sample_in_r   = '0;
        // Both model stages start from an all-zero history
        foreach (mh[s, c, i]) begin
            mh[s][c][i] = '0;
        end
        repeat (10) @(posedge reset);
        clk <= 1'b0;

        // Idle after reset
        repeat (20) begin
            @(negedge reset);
            check_strobe("sample_out_rdy before any input", sample_out_rdy, 1'b0);
        end

        // Left impulse with a silent right lane
        right_zero = 1'b1;
        send_sample(18'sd100000, '0, 0);
        repeat (N_IMPULSE - 1) send_sample('0, '0, 0);
        right_zero = 1'b0;

        // DC step settles on all four phases
        repeat (N_DC) send_sample(DC_L, DC_R, 0);
        for (int i = 0; i < 4; i++) begin
            check_sample("DC left phase", last_l[i], DC_L);
            check_sample("DC right phase", last_r[i], DC_R);
        end

        for (int i = 0; i < N_RAND; i++) begin
            vl = lpf_sample_t'($random(seed));
            vr = lpf_sample_t'($random(seed));
            send_sample(vl, vr, 0);
        end

        // Full-scale alternation with one repeated value to line a window up with tap signs
        sat_before = sat_count;
        for (int i = 0; i < N_ALT; i++) begin
            vl = (((i < 9) ? i : i - 1) % 2 == 0) ? FS_POS : FS_NEG;
            vr = (vl == FS_POS) ? FS_NEG : FS_POS;
            send_sample(vl, vr, 0);
        end
        if (sat_count == sat_before) begin
            stop_run("Full-scale pattern never drove the model into saturation");
        end

        // Early second strobe is dropped
        cnt_before = out_count;
        send_sample(18'sd12345, -18'sd2345, 5);
        repeat (SPACING) @(posedge reset);
        check_count("outputs after a dropped strobe", out_count - cnt_before, 4);

        if (err_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "Checks failed");
        end
    end

endmodule

/* interp_chain.f */
+incdir+design
design/lpf_pkg.sv
design/sample_fifo.sv
design/mac_unit.sv
design/halfband_interp.sv
design/interp_sequencer.sv
design/interp_chain.sv
sim/tb_interp_chain.sv

/* Makefile */
# Verilator build for the stereo 4x interpolator chain
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_interp_chain
FILELIST  ?= interp_chain.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status is nonzero when the testbench stops with $$fatal
run: compile
	./$(BINARY)

clean:
	rm -rf $(OBJ_DIR)
